// ==== burst_addr_gen.sv ====
/* AR channel generator. on each accepted line start it walks the four
   screen regions of the current row and issues BURSTS_PER_SEG bursts
   per region, one cycle of arvalid low between requests */

`timescale 1ns/1ps
`default_nettype none

module burst_addr_gen #(
    parameter int BURST_LEN      = 8,
    parameter int BURSTS_PER_SEG = 4,
    parameter int ROWS           = 180,
    parameter int REGION_STRIDE  = 60000,
    parameter int BANK_OFFSET    = 30000
) (
    input  wire                   clk,
    input  wire                   rst,
    input  wire                   init_done,
    input  wire                   frame_sel,
    input  wire                   line_start,
    input  wire                   frame_start,
    input  wire                   axi_arready,
    output logic                  axi_arvalid,
    output video_read_pkg::addr_t axi_araddr
);

    localparam int ADDR_STEP = BURST_LEN * 8;            // addresses per burst
    localparam int ROW_STEP  = BURSTS_PER_SEG * ADDR_STEP;

    video_read_pkg::gen_state_t state;
    video_read_pkg::row_t       row;
    video_read_pkg::row_t       row_first;
    video_read_pkg::region_t    region;
    video_read_pkg::burst_cnt_t burst;   // burst within the segment

    logic bank_sel;       // frame_sel captured at line start
    logic frame_pending;  // frame start seen while busy
    logic start_ok;
    logic restart;
    logic handshake;
    logic seg_last;
    logic line_last;

    function automatic video_read_pkg::addr_t addr_calc(
        input video_read_pkg::region_t    r,
        input video_read_pkg::burst_cnt_t b,
        input video_read_pkg::row_t       n,
        input logic                       bank
    );
        logic [31:0] sum;
        sum = 32'(r) * REGION_STRIDE
            + (bank ? BANK_OFFSET : 0)
            + 32'(n) * ROW_STEP
            + 32'(b) * ADDR_STEP;
        return sum[video_read_pkg::ADDR_WIDTH-1:0];
    endfunction

    assign start_ok  = (state == video_read_pkg::IDLE) && line_start && init_done;
    assign restart   = frame_start || frame_pending;
    assign row_first = restart ? '0 : row;   // vsync restarts the picture
    assign handshake = axi_arvalid && axi_arready;
    assign seg_last  = (burst == BURSTS_PER_SEG - 1);
    assign line_last = seg_last && (region == video_read_pkg::NUM_REGIONS - 1);

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state       <= video_read_pkg::IDLE;
            axi_arvalid <= 1'b0;
            row         <= '0;
            region      <= '0;
            burst       <= '0;
            bank_sel    <= 1'b0;
        end else begin
            case (state)
                video_read_pkg::IDLE: begin
                    if (start_ok) begin
                        state       <= video_read_pkg::ISSUE;
                        axi_arvalid <= 1'b1;
                        region      <= '0;
                        burst       <= '0;
                        row         <= row_first;
                        bank_sel    <= frame_sel;
                    end
                end
                video_read_pkg::ISSUE: begin
                    if (handshake) begin
                        axi_arvalid <= 1'b0;
                        if (line_last) begin
                            state <= video_read_pkg::IDLE;
                            // next row, wrap at end of picture
                            if (row == ROWS - 1)
                                row <= '0;
                            else
                                row <= row + 1'b1;
                        end else begin
                            state <= video_read_pkg::GAP;
                            if (seg_last) begin
                                burst  <= '0;
                                region <= region + 1'b1;
                            end else begin
                                burst <= burst + 1'b1;
                            end
                        end
                    end
                end
                video_read_pkg::GAP: begin
                    state       <= video_read_pkg::ISSUE;
                    axi_arvalid <= 1'b1;
                end
                default: begin
                    state       <= video_read_pkg::IDLE;
                    axi_arvalid <= 1'b0;
                end
            endcase
        end
    end

    // frame start outside IDLE waits for the next accepted line
    always_ff @(posedge clk or negedge rst) begin
        if (!rst)
            frame_pending <= 1'b0;
        else if (start_ok)
            frame_pending <= 1'b0;
        else if (frame_start)
            frame_pending <= 1'b1;
    end

    // address loads only when arvalid is about to rise, so it holds under back-pressure
    always_ff @(posedge clk) begin
        if (start_ok)
            axi_araddr <= addr_calc('0, '0, row_first, frame_sel);
        else if (state == video_read_pkg::GAP)
            axi_araddr <= addr_calc(region, burst, row, bank_sel);
    end

endmodule

`default_nettype wire

// ==== files.f ====
video_read_pkg.sv
line_trigger.sv
burst_addr_gen.sv
read_data_router.sv
quad_video_reader.sv
quad_video_reader_checker.sv
tb_quad_video_reader.sv

// ==== line_trigger.sv ====
/* line and frame start detection from the HDMI sync inputs.
   both inputs pass a two-flop synchronizer, a falling edge of either
   one gives a registered line_start, a vsync fall also gives frame_start */

`timescale 1ns/1ps
`default_nettype none

module line_trigger (
    input  wire  clk,
    input  wire  rst,
    input  wire  hdmi_vsync,
    input  wire  hdmi_href,
    output logic line_start,
    output logic frame_start
);

    // bit 1 is vsync, bit 0 is href
    logic [1:0] sync_s1;
    logic [1:0] sync_s2;
    logic [1:0] sync_d;   // previous synchronized value
    logic [1:0] fall;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            sync_s1 <= '0;
            sync_s2 <= '0;
            sync_d  <= '0;
        end else begin
            sync_s1 <= {hdmi_vsync, hdmi_href};
            sync_s2 <= sync_s1;
            sync_d  <= sync_s2;
        end
    end

    assign fall = sync_d & ~sync_s2;

    // one-cycle pulses, third edge after the input fall
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            line_start  <= 1'b0;
            frame_start <= 1'b0;
        end else begin
            line_start  <= |fall;
            frame_start <= fall[1];
        end
    end

endmodule

`default_nettype wire

// ==== quad_video_reader.sv ====
/* top of the four-way split-screen read engine. sync edges start a
   line, the generator issues AXI read bursts and the router hands the
   returning beats to the line buffer with their region tag */

`timescale 1ns/1ps
`default_nettype none

module quad_video_reader #(
    parameter int DATA_WIDTH     = 256,
    parameter int BURST_LEN      = 8,
    parameter int BURSTS_PER_SEG = 4,
    parameter int ROWS           = 180,
    parameter int REGION_STRIDE  = 60000,
    parameter int BANK_OFFSET    = 30000
) (
    input  wire                     clk,
    input  wire                     rst,
    input  wire                     init_done,
    input  wire                     frame_sel,    // frame bank, sampled per line
    input  wire                     hdmi_vsync,
    input  wire                     hdmi_href,

    // AXI read address channel
    output logic                    axi_arvalid,
    input  wire                     axi_arready,
    output video_read_pkg::addr_t   axi_araddr,
    output logic [3:0]              axi_arid,
    output logic [3:0]              axi_arlen,
    output logic [2:0]              axi_arsize,
    output logic [1:0]              axi_arburst,

    // AXI read data channel
    output logic                    axi_rready,
    input  wire  [DATA_WIDTH-1:0]   axi_rdata,
    input  wire                     axi_rvalid,
    input  wire                     axi_rlast,

    // line buffer write port
    output logic                    buf_wr_en,
    output video_read_pkg::region_t buf_wr_region,
    output logic [DATA_WIDTH-1:0]   buf_wr_data
);

    logic line_start;
    logic frame_start;

    // fixed AR fields
    assign axi_arid    = 4'd0;
    assign axi_arlen   = 4'(BURST_LEN - 1);
    assign axi_arsize  = 3'($clog2(DATA_WIDTH / 8));  // 32 bytes per beat
    assign axi_arburst = 2'b01;                       // INCR
    assign axi_rready  = 1'b1;                        // R is never stalled

    line_trigger trigger_i (
        .clk         (clk),
        .rst         (rst),
        .hdmi_vsync  (hdmi_vsync),
        .hdmi_href   (hdmi_href),
        .line_start  (line_start),
        .frame_start (frame_start)
    );

    burst_addr_gen #(
        .BURST_LEN      (BURST_LEN),
        .BURSTS_PER_SEG (BURSTS_PER_SEG),
        .ROWS           (ROWS),
        .REGION_STRIDE  (REGION_STRIDE),
        .BANK_OFFSET    (BANK_OFFSET)
    ) addr_gen_i (
        .clk         (clk),
        .rst         (rst),
        .init_done   (init_done),
        .frame_sel   (frame_sel),
        .line_start  (line_start),
        .frame_start (frame_start),
        .axi_arready (axi_arready),
        .axi_arvalid (axi_arvalid),
        .axi_araddr  (axi_araddr)
    );

    read_data_router #(
        .DATA_WIDTH     (DATA_WIDTH),
        .BURSTS_PER_SEG (BURSTS_PER_SEG)
    ) router_i (
        .clk           (clk),
        .rst           (rst),
        .line_start    (line_start),
        .axi_rvalid    (axi_rvalid),
        .axi_rlast     (axi_rlast),
        .axi_rdata     (axi_rdata),
        .buf_wr_en     (buf_wr_en),
        .buf_wr_region (buf_wr_region),
        .buf_wr_data   (buf_wr_data)
    );

endmodule

`default_nettype wire

// ==== quad_video_reader_checker.sv ====
/* AXI read protocol checks for the quad video reader.
   bound into the top level, counts its own assertion failures */

`timescale 1ns/1ps
`default_nettype none

module quad_video_reader_checker (
    input wire                        clk,
    input wire                        rst,
    input wire                        init_done,
    input wire                        axi_arvalid,
    input wire                        axi_arready,
    input wire video_read_pkg::addr_t axi_araddr,
    input wire                        axi_rvalid,
    input wire                        buf_wr_en
);

    int fail_count = 0;

    // pending request keeps its address until taken
    ar_hold: assert property (@(posedge clk) disable iff (!rst)
        axi_arvalid && !axi_arready |=> axi_arvalid && $stable(axi_araddr))
    else begin
        $error("arvalid dropped or araddr changed before arready");
        fail_count++;
    end

    ar_gap: assert property (@(posedge clk) disable iff (!rst)
        axi_arvalid && axi_arready |=> !axi_arvalid)  // one low cycle between bursts
    else begin
        $error("arvalid still high in the cycle after a handshake");
        fail_count++;
    end

    no_req_before_init: assert property (@(posedge clk) disable iff (!rst)
        !init_done |-> !axi_arvalid)
    else begin
        $error("AR request while the memory controller is not initialized");
        fail_count++;
    end

    wr_follows_r: assert property (@(posedge clk) disable iff (!rst)
        buf_wr_en == axi_rvalid)
    else begin
        $error("buf_wr_en differs from rvalid");
        fail_count++;
    end

endmodule

bind quad_video_reader quad_video_reader_checker checker_i (
    .clk         (clk),
    .rst         (rst),
    .init_done   (init_done),
    .axi_arvalid (axi_arvalid),
    .axi_arready (axi_arready),
    .axi_araddr  (axi_araddr),
    .axi_rvalid  (axi_rvalid),
    .buf_wr_en   (buf_wr_en)
);

`default_nettype wire

// ==== read_data_router.sv ====
/* R channel router. counts the rlast beats of a line and tags every
   returning beat with the region of the burst it belongs to, so bursts
   still in flight at a line boundary keep the right tag */

`timescale 1ns/1ps
`default_nettype none

module read_data_router #(
    parameter int DATA_WIDTH     = 256,
    parameter int BURSTS_PER_SEG = 4
) (
    input  wire                     clk,
    input  wire                     rst,
    input  wire                     line_start,
    input  wire                     axi_rvalid,
    input  wire                     axi_rlast,
    input  wire  [DATA_WIDTH-1:0]   axi_rdata,
    output logic                    buf_wr_en,
    output video_read_pkg::region_t buf_wr_region,
    output logic [DATA_WIDTH-1:0]   buf_wr_data
);

    localparam int LINE_BURSTS = video_read_pkg::NUM_REGIONS * BURSTS_PER_SEG;

    video_read_pkg::burst_cnt_t burst_cnt;  // completed bursts of this line

    logic line_open;    // a line's data is expected
    logic line_queued;  // another line start came while open
    logic burst_done;
    logic line_done;

    assign burst_done = axi_rvalid && axi_rlast;
    assign line_done  = burst_done && (burst_cnt == LINE_BURSTS - 1);

    always_ff @(posedge clk or negedge rst) begin
        if (!rst)
            burst_cnt <= '0;
        else if (line_start && !line_open)
            burst_cnt <= '0;                 // resync at an idle line start
        else if (line_done)
            burst_cnt <= '0;
        else if (burst_done)
            burst_cnt <= burst_cnt + 1'b1;
    end

    // line starts during a line must not clear the count
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            line_open   <= 1'b0;
            line_queued <= 1'b0;
        end else if (line_done) begin
            line_open   <= line_queued || line_start;
            line_queued <= 1'b0;
        end else if (line_start) begin
            if (line_open)
                line_queued <= 1'b1;
            line_open <= 1'b1;
        end
    end

    assign buf_wr_en     = axi_rvalid;
    assign buf_wr_data   = axi_rdata;
    assign buf_wr_region = video_read_pkg::region_t'(burst_cnt / BURSTS_PER_SEG);

endmodule

`default_nettype wire

// ==== tb_quad_video_reader.sv ====
/* testbench for the quad split-screen read engine. drives sync edges,
   models an AXI memory with a request queue and random timing, and
   checks every AR address and every line buffer beat */

`timescale 1ns/1ps
`default_nettype none

module tb_quad_video_reader;

    localparam int DATA_WIDTH     = 256;
    localparam int BURST_LEN      = 8;
    localparam int BURSTS_PER_SEG = 4;
    localparam int ROWS           = 180;
    localparam int REGION_STRIDE  = 60000;
    localparam int BANK_OFFSET    = 30000;
    localparam int ADDR_STEP      = BURST_LEN * 8;
    localparam int AW             = video_read_pkg::ADDR_WIDTH;
    localparam int TOTAL_LINES    = ROWS + 11;
    localparam int WATCHDOG_CYCLES =
        TOTAL_LINES * 4 * BURSTS_PER_SEG * (BURST_LEN + 20) + 1000;

    logic                  clk = 1'b0;
    logic                  rst = 1'b0;
    logic                  init_done = 1'b0;
    logic                  frame_sel = 1'b0;
    logic                  hdmi_vsync = 1'b0;
    logic                  hdmi_href = 1'b0;
    logic                  axi_arready = 1'b0;
    logic                  axi_rvalid = 1'b0;
    logic                  axi_rlast = 1'b0;
    logic [DATA_WIDTH-1:0] axi_rdata = '0;
    logic                  axi_arvalid;
    video_read_pkg::addr_t axi_araddr;
    logic [3:0]            axi_arid;
    logic [3:0]            axi_arlen;
    logic [2:0]            axi_arsize;
    logic [1:0]            axi_arburst;
    logic                  axi_rready;
    logic                  buf_wr_en;
    video_read_pkg::region_t buf_wr_region;
    logic [DATA_WIDTH-1:0] buf_wr_data;

    // queue entries carry {bank, address}
    logic [AW:0] exp_q[$];
    logic [AW:0] mem_q[$];
    logic [AW:0] ar_exp;
    logic [AW:0] cur_burst;
    logic [31:0] lcg_state = 32'hd76b;
    logic [31:0] rnd;
    int          beat_idx = -1;  // -1 while no burst is returning
    int          gap_left = 0;
    int          region_exp;
    int          exp_row = 0;
    int          bursts_accepted = 0;
    int          beats_seen = 0;
    string       test_name = "reset";

    quad_video_reader #(
        .DATA_WIDTH     (DATA_WIDTH),
        .BURST_LEN      (BURST_LEN),
        .BURSTS_PER_SEG (BURSTS_PER_SEG),
        .ROWS           (ROWS),
        .REGION_STRIDE  (REGION_STRIDE),
        .BANK_OFFSET    (BANK_OFFSET)
    ) dut_i (.*);

    always #50 clk = ~clk;

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic video_read_pkg::addr_t expected_addr(
        input int region, input int burst, input int row, input bit bank);
        longint a;
        a = longint'(region) * REGION_STRIDE + (bank ? BANK_OFFSET : 0)
          + longint'(row) * BURSTS_PER_SEG * ADDR_STEP + longint'(burst) * ADDR_STEP;
        return video_read_pkg::addr_t'(a);
    endfunction

    task automatic stop_with(input string msg);
        $display("%s", msg);
        $display("Simulation finished: FAIL");
        $fatal(1);
    endtask

    task automatic fail_value(input string what, input longint expected, input longint actual);
        stop_with($sformatf("FAIL %s %s: expected %0h, actual %0h",
                            test_name, what, expected, actual));
    endtask

    // raise one sync input for a few cycles, then let it fall
    task automatic sync_fall(input bit on_vsync);
        if (on_vsync)
            hdmi_vsync = 1'b1;
        else
            hdmi_href = 1'b1;
        repeat (3) @(negedge clk);
        if (on_vsync)
            hdmi_vsync = 1'b0;
        else
            hdmi_href = 1'b0;
        @(negedge clk);
    endtask

    task automatic start_line(input bit on_vsync, input bit bank);
        int r;
        int b;
        if (on_vsync)
            exp_row = 0;
        frame_sel = bank;
        for (r = 0; r < video_read_pkg::NUM_REGIONS; r++)
            for (b = 0; b < BURSTS_PER_SEG; b++)
                exp_q.push_back({bank, expected_addr(r, b, exp_row, bank)});
        sync_fall(on_vsync);
    endtask

    task automatic finish_line();
        while (exp_q.size() != 0) @(negedge clk);  // all AR requests of the line
        exp_row = (exp_row == ROWS - 1) ? 0 : exp_row + 1;
        while (beats_seen != bursts_accepted * BURST_LEN) @(negedge clk);
    endtask

    // AR scoreboard feeding the memory model
    always @(posedge clk) begin
        if (rst) begin
            assert (axi_rready == 1'b1)
            else fail_value("rready", 1, axi_rready);
        end
        if (rst && axi_arvalid && axi_arready) begin
            assert (exp_q.size() != 0)
            else stop_with("AR request issued while no line was expected");
            if (exp_q.size() != 0) begin
                ar_exp = exp_q.pop_front();
                assert (axi_araddr == ar_exp[AW-1:0])
                else fail_value("araddr", ar_exp[AW-1:0], axi_araddr);
                assert (axi_arid == 4'd0)
                else fail_value("arid", 0, axi_arid);
                assert (axi_arlen == 4'(BURST_LEN - 1))
                else fail_value("arlen", BURST_LEN - 1, axi_arlen);
                assert (axi_arsize == 3'd5)  // 32-byte beats
                else fail_value("arsize", 5, axi_arsize);
                assert (axi_arburst == 2'b01)
                else fail_value("arburst", 1, axi_arburst);
                mem_q.push_back({ar_exp[AW], axi_araddr});
                bursts_accepted++;
            end
        end
    end

    // region tag taken back from the address in the beat
    always @(posedge clk) begin
        if (rst && buf_wr_en) begin
            region_exp = (int'(axi_rdata[AW-1:0]) - (axi_rdata[AW] ? BANK_OFFSET : 0))
                       / REGION_STRIDE;
            assert (buf_wr_region == region_exp)
            else fail_value("buf_wr_region", region_exp, buf_wr_region);
            assert (buf_wr_data == axi_rdata)
            else fail_value("buf_wr_data", axi_rdata[63:0], buf_wr_data[63:0]);
            beats_seen++;
        end
    end

    // memory model with random arready and in-order bursts after random gaps
    always @(negedge clk) begin
        rnd = next_rand();
        axi_arready = (rnd[21:20] != 2'b00);
        axi_rvalid  = 1'b0;
        axi_rlast   = 1'b0;
        if (beat_idx < 0 && mem_q.size() != 0) begin
            if (gap_left == 0) begin
                cur_burst = mem_q.pop_front();
                beat_idx  = 0;
                gap_left  = int'(rnd[25:24]);
            end else begin
                gap_left--;
            end
        end
        if (beat_idx >= 0) begin
            axi_rvalid = 1'b1;
            axi_rdata  = '0;
            axi_rdata[AW:0]  = cur_burst;
            axi_rdata[47:40] = 8'(beat_idx);
            axi_rlast  = (beat_idx == BURST_LEN - 1);
            beat_idx   = (beat_idx == BURST_LEN - 1) ? -1 : beat_idx + 1;
        end
    end

    always @(negedge clk) begin
        if (dut_i.checker_i.fail_count != 0)
            stop_with("a protocol assertion in the checker failed");
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        stop_with("watchdog timeout, the line sequence did not complete in time");
    end

    initial begin
        int i;
        repeat (2) @(negedge clk);
        rst = 1'b1;
        @(negedge clk);

        test_name = "init_done_low";
        sync_fall(1'b0);
        sync_fall(1'b0);
        repeat (8) @(negedge clk);
        init_done = 1'b1;
        start_line(1'b1, 1'b0);
        finish_line();

        test_name = "successive_lines";
        repeat (3) begin
            start_line(1'b0, 1'b0);
            finish_line();
        end

        test_name = "bank_select";
        start_line(1'b0, 1'b1);
        finish_line();
        start_line(1'b0, 1'b1);
        while (exp_q.size() > 8) @(negedge clk);
        frame_sel = 1'b0;  // must not reach this line
        finish_line();
        start_line(1'b0, 1'b0);
        finish_line();

        test_name = "row_wrap";
        start_line(1'b1, 1'b0);
        finish_line();
        for (i = 0; i < ROWS + 1; i++) begin
            start_line(1'b0, i[0]);
            finish_line();
        end

        test_name = "edge_during_line";
        start_line(1'b0, 1'b0);
        while (exp_q.size() > 12) @(negedge clk);
        sync_fall(1'b0);  // lands while the line is issuing
        finish_line();
        start_line(1'b0, 1'b0);
        finish_line();

        repeat (4) @(negedge clk);
        if (dut_i.checker_i.fail_count == 0 && exp_q.size() == 0) begin
            $display("Simulation finished: PASS");
            $finish;
        end else begin
            stop_with("requests or protocol errors left over at the end");
        end
    end

endmodule

`default_nettype wire

// ==== video_read_pkg.sv ====
/* shared definitions for the quad split-screen read engine:
   DDR address geometry, vector types and the burst generator states */

`default_nettype none

package video_read_pkg;

    // DDR controller address fields
    localparam int MEM_ROW_WIDTH    = 15;
    localparam int MEM_BANK_WIDTH   = 3;
    localparam int MEM_COLUMN_WIDTH = 10;

    localparam int ADDR_WIDTH = MEM_ROW_WIDTH + MEM_BANK_WIDTH + MEM_COLUMN_WIDTH;

    localparam int NUM_REGIONS = 4;  // screen quarters read per line

    // controller word address
    typedef logic [ADDR_WIDTH-1:0] addr_t;

    typedef logic [1:0] region_t;     // region index 0..3
    typedef logic [10:0] row_t;       // picture row
    typedef logic [7:0] burst_cnt_t;  // bursts within a line

    // burst generator FSM
    typedef enum logic [1:0] {
        IDLE,   // waiting for a line start
        ISSUE,  // arvalid high
        GAP     // one idle cycle between bursts
    } gen_state_t;

endpackage

`default_nettype wire
